// ==== all.f ====
verilog/mdc_pkg.sv
verilog/hamming_decoder.sv
verilog/matrix_buffer.sv
verilog/det_sequencer.sv
verilog/det_engine.sv
verilog/result_packer.sv
verilog/mdc_top.sv
sim/tb_mdc.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the determinant calculator testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mdc -f all.f \
    -o tb_mdc_sim > build.log 2>&1 \
    && ./obj_dir/tb_mdc_sim > sim.log 2>&1 \
    || echo "build or run failed, see build.log and sim.log"
grep -qsx "test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== sim/tb_mdc.sv ====
// Matrix determinant calculator testbench
`timescale 1ns/1ns

module tb_mdc
    import mdc_pkg::*;
();

    localparam int N_ROWS    = 16;
    localparam int CYCLE_LIM = 40 * N_ROWS + 20;
    // Cycles from the last entry to out_valid on top of one per job
    localparam int PIPE_LAT  = 3;

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid;
    logic [CODE_W-1:0]      in_data;
    logic [MODE_CODE_W-1:0] in_mode;
    logic                   out_valid;
    logic [OUT_W-1:0]       out_data;

    // Stimulus table, error positions count from the codeword MSB, 0 is clean
    matrix_t          tbl_entry [N_ROWS];
    logic [4:0]       tbl_mode  [N_ROWS];
    logic [15:0][3:0] tbl_err   [N_ROWS];
    logic [3:0]       tbl_merr  [N_ROWS];

    integer seed;
    int     errors;
    int     cycles;

    mdc_top mdc_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_mode   (in_mode),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ==================================================================
    // Encoder and reference model
    // ==================================================================
    // Data first, then each parity bit cancels its syndrome bit
    function automatic logic [CODE_W-1:0] encode(input logic [ENTRY_W-1:0] d,
                                                 input int k, input int n);
        logic [CODE_W-1:0] cw;
        int                syn;
        int                j;
        cw  = '0;
        syn = 0;
        j   = k - 1;
        for (int p = 1; p <= n; p++) begin
            if ((p & (p - 1)) != 0) begin
                cw[n-p] = d[j];
                if (d[j]) begin
                    syn = syn ^ p;
                end
                j = j - 1;
            end
        end
        for (int b = 1; b < n; b = b * 2) begin
            if ((syn & b) != 0) begin
                cw[n-b] = 1'b1;
            end
        end
        return cw;
    endfunction

    function automatic longint det2(input matrix_t m, input int r, input int c);
        longint a;
        longint b;
        longint e;
        longint d;
        a = m[4*r+c];
        b = m[4*r+c+1];
        e = m[4*(r+1)+c];
        d = m[4*(r+1)+c+1];
        return a * d - b * e;
    endfunction

    // Rule of Sarrus
    function automatic longint det3(input matrix_t m, input int r, input int c);
        longint a [3][3];
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                a[i][j] = m[4*(r+i)+c+j];
            end
        end
        return a[0][0] * a[1][1] * a[2][2] + a[0][1] * a[1][2] * a[2][0]
             + a[0][2] * a[1][0] * a[2][1] - a[0][2] * a[1][1] * a[2][0]
             - a[0][0] * a[1][2] * a[2][1] - a[0][1] * a[1][0] * a[2][2];
    endfunction

    function automatic logic [OUT_W-1:0] expected_word(input matrix_t m,
                                                       input logic [4:0] mode);
        logic [OUT_W-1:0] w;
        longint           d;
        w = '0;
        if (mode == 5'b00110) begin
            for (int k = 0; k < 4; k++) begin
                d = det3(m, k / 2, k % 2);
                w[OUT_W-4-MINOR3_W*k -: MINOR3_W] = d[MINOR3_W-1:0];
            end
        end else begin
            for (int k = 0; k < 9; k++) begin
                d = det2(m, k / 3, k % 3);
                w[OUT_W-1-MINOR2_W*k -: MINOR2_W] = d[MINOR2_W-1:0];
            end
        end
        return w;
    endfunction

    // ==================================================================
    // Stimulus
    // ==================================================================
    task automatic fill_table();
        for (int r = 0; r < N_ROWS; r++) begin
            tbl_err[r]  = '0;
            tbl_merr[r] = '0;
            tbl_mode[r] = (r % 2 == 1) ? 5'b00110 : 5'b00000;
            for (int i = 0; i < N_ENTRIES; i++) begin
                tbl_entry[r][i] = entry_t'((i * i * 37 + i * 113) % 2000 - 1000);
                if (r >= 2 && r <= 10) begin
                    tbl_err[r][i] = 4'((i + r) % 15 + 1);
                end else if (r == 11 || r == 12) begin
                    tbl_entry[r][i] = (i % 3 == 1) ? 11'sd1023 : -11'sd1024;
                end else if (r == 13) begin
                    tbl_entry[r][i] = ((i / 4 + i) % 3 == 0) ? -11'sd1024 : 11'sd1023;
                end else if (r >= 14) begin
                    tbl_entry[r][i] = entry_t'($random(seed));
                    tbl_err[r][i]   = 4'($unsigned($random(seed)) % 16);
                end
            end
            if (r >= 2 && r <= 10) begin
                tbl_merr[r] = 4'(r - 1);
            end
        end
        // Unused codes fall back to 2x2, including the old 4x4 code
        tbl_mode[11] = 5'b10110;
        tbl_mode[12] = 5'b00110;
        tbl_mode[13] = 5'b00110;
        tbl_mode[14] = 5'b11111;
        tbl_mode[15] = 5'b00110;
        tbl_merr[15] = 4'($unsigned($random(seed)) % 10);
    endtask

    task automatic drive_frame(input int r);
        logic [CODE_W-1:0] cw;
        logic [CODE_W-1:0] mcw;
        int                e;
        mcw = encode(ENTRY_W'(tbl_mode[r]), MODE_W, MODE_CODE_W);
        e   = tbl_merr[r];
        if (e != 0) begin
            mcw[MODE_CODE_W-e] = ~mcw[MODE_CODE_W-e];
        end
        for (int i = 0; i < N_ENTRIES; i++) begin
            cw = encode(tbl_entry[r][i], ENTRY_W, CODE_W);
            e  = tbl_err[r][i];
            if (e != 0) begin
                cw[CODE_W-e] = ~cw[CODE_W-e];
            end
            in_valid = 1'b1;
            in_data  = cw;
            in_mode  = (i == 0) ? mcw[MODE_CODE_W-1:0] : '0;
            @(negedge clk);
        end
        in_valid = 1'b0;
        in_data  = '0;
        in_mode  = '0;
    endtask

    initial begin
        int               lat;
        int               n_jobs;
        logic [OUT_W-1:0] exp_word;
        seed     = 32'h394a;
        errors   = 0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_data  = '0;
        in_mode  = '0;
        fill_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        if (out_valid !== 1'b0 || out_data !== '0) begin
            $display("Error at %0t: outputs not idle after reset", $time);
            errors++;
        end
        for (int r = 0; r < N_ROWS; r++) begin
            exp_word = expected_word(tbl_entry[r], tbl_mode[r]);
            n_jobs   = (tbl_mode[r] == 5'b00110) ? 4 : 9;
            drive_frame(r);
            // Now just past the edge that sampled the last entry
            lat = 0;
            while (out_valid !== 1'b1) begin
                if (out_data !== '0) begin
                    $display("Error at %0t: row %0d out_data not zero while idle", $time, r);
                    errors++;
                end
                @(negedge clk);
                lat++;
            end
            if (lat != n_jobs + PIPE_LAT) begin
                $display("Error at %0t: row %0d latency %0d, expected %0d",
                         $time, r, lat, n_jobs + PIPE_LAT);
                errors++;
            end
            if (out_data !== exp_word) begin
                $display("Error at %0t: row %0d out_data %h, expected %h",
                         $time, r, out_data, exp_word);
                errors++;
            end
            @(negedge clk);
            if (out_valid !== 1'b0 || out_data !== '0) begin
                $display("Error at %0t: row %0d out_valid held past one cycle", $time, r);
                errors++;
            end
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Run limit
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIM) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIM);
        $display("test failed");
        $finish;
    end

endmodule

// ==== verilog/det_engine.sv ====
// Pipelined 3x3 determinant engine
`timescale 1ns/1ns

module det_engine
    import mdc_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  det_req_t req,
    output det_rsp_t rsp
);

    localparam int PROD_W = 2 * ENTRY_W;
    localparam int TERM_W = ENTRY_W + MINOR2_W;
    localparam int SUM_W  = TERM_W + 2;

    // Stage one products of the lower two rows
    logic signed [PROD_W-1:0]   p_11_22;
    logic signed [PROD_W-1:0]   p_12_21;
    logic signed [PROD_W-1:0]   p_10_22;
    logic signed [PROD_W-1:0]   p_12_20;
    logic signed [PROD_W-1:0]   p_10_21;
    logic signed [PROD_W-1:0]   p_11_20;
    logic signed [MINOR2_W-1:0] minor0_q;
    logic signed [MINOR2_W-1:0] minor1_q;
    logic signed [MINOR2_W-1:0] minor2_q;
    entry_t                     top0_q;
    entry_t                     top1_q;
    entry_t                     top2_q;
    logic                       s1_valid;
    logic                       s1_last;

    // Stage two
    logic signed [TERM_W-1:0]   term0;
    logic signed [TERM_W-1:0]   term1;
    logic signed [TERM_W-1:0]   term2;
    logic signed [SUM_W-1:0]    det_sum;
    logic signed [MINOR3_W-1:0] det_q;
    logic                       rsp_valid;
    logic                       rsp_last;

    // ==================================================================
    // Stage 1
    // ==================================================================
    assign p_11_22 = req.m11 * req.m22;
    assign p_12_21 = req.m12 * req.m21;
    assign p_10_22 = req.m10 * req.m22;
    assign p_12_20 = req.m12 * req.m20;
    assign p_10_21 = req.m10 * req.m21;
    assign p_11_20 = req.m11 * req.m20;

    always_ff @(posedge clk) begin
        minor0_q <= p_11_22 - p_12_21;
        minor1_q <= p_10_22 - p_12_20;
        minor2_q <= p_10_21 - p_11_20;
        top0_q   <= req.m00;
        top1_q   <= req.m01;
        top2_q   <= req.m02;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_last  <= 1'b0;
        end else begin
            s1_valid <= req.valid;
            s1_last  <= req.valid && req.last;
        end
    end

    // ==================================================================
    // Stage 2
    // ==================================================================
    // Cofactor expansion along the top row, signs + - +
    assign term0   = top0_q * minor0_q;
    assign term1   = top1_q * minor1_q;
    assign term2   = top2_q * minor2_q;
    assign det_sum = term0 - term1 + term2;

    always_ff @(posedge clk) begin
        det_q <= MINOR3_W'(det_sum);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
            rsp_last  <= 1'b0;
        end else begin
            rsp_valid <= s1_valid;
            rsp_last  <= s1_last;
        end
    end

    assign rsp = '{valid: rsp_valid, last: rsp_last, value: det_q};

endmodule

// ==== verilog/det_sequencer.sv ====
// Submatrix job sequencer
`timescale 1ns/1ns

module det_sequencer
    import mdc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      frame_done,
    input  matrix_t   matrix,
    input  det_mode_e mode,
    output det_req_t  req
);

    logic       busy;
    logic [1:0] pos_row;
    logic [1:0] pos_col;
    logic [1:0] pos_max;
    logic       pos_last;
    logic [3:0] base;
    det_req_t   job;

    // Highest window offset, 2 for 2x2 and 1 for 3x3
    assign pos_max  = (mode == MODE_3X3) ? 2'd1 : 2'd2;
    assign pos_last = (pos_row == pos_max) && (pos_col == pos_max);
    // Row stride is 4 so the top-left index is just {row, col}
    assign base     = {pos_row, pos_col};

    // ==================================================================
    // Window position walk
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            pos_row <= '0;
            pos_col <= '0;
        end else if (frame_done) begin
            busy    <= 1'b1;
            pos_row <= '0;
            pos_col <= '0;
        end else if (busy) begin
            if (pos_last) begin
                busy <= 1'b0;
            end
            if (pos_col == pos_max) begin
                pos_col <= '0;
                pos_row <= pos_row + 2'd1;
            end else begin
                pos_col <= pos_col + 2'd1;
            end
        end
    end

    // ==================================================================
    // Job build
    // ==================================================================
    always_comb begin
        job       = '0;
        job.valid = busy;
        job.last  = busy && pos_last;
        if (mode == MODE_3X3) begin
            job.m00 = matrix[base];
            job.m01 = matrix[base + 4'd1];
            job.m02 = matrix[base + 4'd2];
            job.m10 = matrix[base + 4'd4];
            job.m11 = matrix[base + 4'd5];
            job.m12 = matrix[base + 4'd6];
            job.m20 = matrix[base + 4'd8];
            job.m21 = matrix[base + 4'd9];
            job.m22 = matrix[base + 4'd10];
        end else begin
            // 2x2 window under a 1,0,0 top row
            job.m00 = entry_t'(1);
            job.m11 = matrix[base];
            job.m12 = matrix[base + 4'd1];
            job.m21 = matrix[base + 4'd4];
            job.m22 = matrix[base + 4'd5];
        end
    end

    assign req = job;

    no_overlap: assert property (
        @(posedge clk) disable iff (!rst_n) frame_done |-> !busy
    ) else $error("det_sequencer: new frame while jobs still issuing");

endmodule

// ==== verilog/hamming_decoder.sv ====
// Hamming single error corrector
`timescale 1ns/1ns

module hamming_decoder #(
    parameter int  DATA_W = 11,
    localparam int PAR_W  = $clog2(DATA_W + $clog2(DATA_W) + 1),
    localparam int CODE_N = DATA_W + PAR_W
) (
    input  logic [CODE_N-1:0] code,
    output logic [DATA_W-1:0] data
);

    logic [PAR_W-1:0]  syndrome;
    logic [CODE_N-1:0] fixed;

    // XOR of the positions of all set bits
    // Position 1 is the codeword MSB
    always_comb begin
        syndrome = '0;
        for (int p = 1; p <= CODE_N; p++) begin
            if (code[CODE_N-p]) begin
                syndrome = syndrome ^ PAR_W'(p);
            end
        end
    end

    // Flip the bit the syndrome points at, zero means clean
    always_comb begin
        for (int p = 1; p <= CODE_N; p++) begin
            fixed[CODE_N-p] = code[CODE_N-p] ^ (int'(syndrome) == p);
        end
    end

    // Data bits sit at non-power-of-two positions, first one is the MSB
    always_comb begin
        int k;
        k    = DATA_W - 1;
        data = '0;
        for (int p = 3; p <= CODE_N; p++) begin
            if ((p & (p - 1)) != 0) begin
                data[k] = fixed[CODE_N-p];
                k       = k - 1;
            end
        end
    end

    // Single-bit errors never point outside the codeword
    always_comb begin
        if (!$isunknown(code)) begin
            assert final (int'(syndrome) <= CODE_N)
                else $error("hamming_decoder: syndrome %0d beyond codeword", syndrome);
        end
    end

endmodule

// ==== verilog/matrix_buffer.sv ====
// Frame entry store and mode latch
`timescale 1ns/1ns

module matrix_buffer
    import mdc_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  entry_t            entry,
    input  logic [MODE_W-1:0] mode_code,
    output matrix_t           matrix,
    output det_mode_e         mode,
    output logic              frame_done
);

    logic [3:0] wr_idx;
    logic       frame_start;
    logic       frame_end;

    assign frame_start = in_valid && (wr_idx == 4'd0);
    assign frame_end   = in_valid && (wr_idx == 4'(N_ENTRIES - 1));

    // ==================================================================
    // Write index
    // ==================================================================
    // Wraps to zero after the sixteenth entry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_idx <= '0;
        end else if (in_valid) begin
            wr_idx <= wr_idx + 4'd1;
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (in_valid) begin
            matrix[wr_idx] <= entry;
        end
    end

    // ==================================================================
    // Frame mode and completion
    // ==================================================================
    // Mode arrives only with the first entry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode <= MODE_2X2;
        end else if (frame_start) begin
            if (mode_code == MODE_3X3_CODE) begin
                mode <= MODE_3X3;
            end else begin
                mode <= MODE_2X2;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_done <= 1'b0;
        end else begin
            frame_done <= frame_end;
        end
    end

    // Frame arrives as sixteen back-to-back entries
    mid_frame_valid: assert property (
        @(posedge clk) disable iff (!rst_n) (wr_idx != 4'd0) |-> in_valid
    ) else $error("matrix_buffer: in_valid dropped mid-frame at index %0d", wr_idx);

endmodule

// ==== verilog/mdc_pkg.sv ====
// Matrix determinant calculator definitions
package mdc_pkg;

    // ==================================================================
    // Widths and constants
    // ==================================================================
    localparam int CODE_W      = 15;
    localparam int ENTRY_W     = 11;
    localparam int MODE_CODE_W = 9;
    localparam int MODE_W      = 5;
    localparam int N_ENTRIES   = 16;

    // Difference of two 22-bit products
    localparam int MINOR2_W = 23;
    localparam int MINOR3_W = 51;
    localparam int OUT_W    = 207;

    // Decoded mode code selecting 3x3 submatrices
    localparam logic [MODE_W-1:0] MODE_3X3_CODE = 5'b00110;

    // ==================================================================
    // Types
    // ==================================================================
    typedef enum logic {
        MODE_2X2 = 1'b0,
        MODE_3X3 = 1'b1
    } det_mode_e;

    typedef logic signed [ENTRY_W-1:0] entry_t;

    // Row-major entries with element 0 at top left
    typedef entry_t [0:N_ENTRIES-1] matrix_t;

    // One 3x3 job for the determinant engine
    typedef struct packed {
        logic   valid;
        logic   last;
        entry_t m00;
        entry_t m01;
        entry_t m02;
        entry_t m10;
        entry_t m11;
        entry_t m12;
        entry_t m20;
        entry_t m21;
        entry_t m22;
    } det_req_t;

    typedef struct packed {
        logic                       valid;
        logic                       last;
        logic signed [MINOR3_W-1:0] value;
    } det_rsp_t;

endpackage

// ==== verilog/mdc_top.sv ====
// Matrix determinant calculator top
`timescale 1ns/1ns

module mdc_top
    import mdc_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  logic [CODE_W-1:0]      in_data,
    input  logic [MODE_CODE_W-1:0] in_mode,
    output logic                   out_valid,
    output logic [OUT_W-1:0]       out_data
);

    entry_t            entry;
    logic [MODE_W-1:0] mode_code;
    matrix_t           matrix;
    det_mode_e         mode;
    logic              frame_done;
    det_req_t          req;
    det_rsp_t          rsp;

    // Input error correction
    hamming_decoder #(.DATA_W(ENTRY_W)) entry_dec (
        .code (in_data),
        .data (entry)
    );

    hamming_decoder #(.DATA_W(MODE_W)) mode_dec (
        .code (in_mode),
        .data (mode_code)
    );

    matrix_buffer matrix_buffer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .entry      (entry),
        .mode_code  (mode_code),
        .matrix     (matrix),
        .mode       (mode),
        .frame_done (frame_done)
    );

    det_sequencer det_sequencer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .frame_done (frame_done),
        .matrix     (matrix),
        .mode       (mode),
        .req        (req)
    );

    det_engine det_engine_i (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .rsp   (rsp)
    );

    result_packer result_packer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rsp       (rsp),
        .mode      (mode),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

// ==== verilog/result_packer.sv ====
// Determinant result packer
`timescale 1ns/1ns

module result_packer
    import mdc_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  det_rsp_t         rsp,
    input  det_mode_e        mode,
    output logic             out_valid,
    output logic [OUT_W-1:0] out_data
);

    // Unused bits above four 3x3 results
    localparam int PAD_W = OUT_W - 4 * MINOR3_W;

    logic [OUT_W-1:0] acc;

    // ==================================================================
    // Accumulator
    // ==================================================================
    // First result ends up in the most significant slot
    always_ff @(posedge clk) begin
        if (rsp.valid) begin
            if (mode == MODE_3X3) begin
                acc <= {acc[OUT_W-MINOR3_W-1:0], rsp.value};
            end else begin
                acc <= {acc[OUT_W-MINOR2_W-1:0], rsp.value[MINOR2_W-1:0]};
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= rsp.valid && rsp.last;
        end
    end

    // ==================================================================
    // Output word
    // ==================================================================
    always_comb begin
        out_data = '0;
        if (out_valid) begin
            out_data = acc;
            // Leftover bits of older shifts
            if (mode == MODE_3X3) begin
                out_data[OUT_W-1 -: PAD_W] = '0;
            end
        end
    end

    single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |=> !out_valid
    ) else $error("result_packer: out_valid held for more than one cycle");

endmodule
